// File: rtl/pe_cfg_pkg.sv
package pe_cfg_pkg;

  // one-hot so the host requests a stage by its bit
  typedef enum logic [2:0] {
    STAGE_IDLE = 3'b000,
    STAGE_PRD  = 3'b001,
    STAGE_NEW  = 3'b010,
    STAGE_UPD  = 3'b100
  } stage_e;

  // stage_rdy levels seen by the host
  localparam logic [2:0] RDY_BUSY  = 3'b000;
  localparam logic [2:0] RDY_READY = 3'b111;

  typedef enum logic [3:0] {
    PRD_IDLE      = 4'b0000,
    PRD_NONLINEAR = 4'b0001,
    PRD_1         = 4'b0010,
    PRD_2         = 4'b0100
  } prd_e;

  // source of the PE M input
  typedef enum logic [1:0] {
    M_SRC_NONE = 2'b00,
    M_SRC_TB   = 2'b01
  } m_src_e;

  localparam int TB_ADDR_W = 12;

  typedef struct packed {
    logic                 en;
    logic                 we;
    logic [TB_ADDR_W-1:0] addr;
  } tb_cmd_t;

  // temp bank layout, one row per address
  localparam logic [TB_ADDR_W-1:0] F_XI   = 12'd0;
  localparam logic [TB_ADDR_W-1:0] F_XI_T = 12'd3;
  localparam logic [TB_ADDR_W-1:0] T_COV  = 12'd6;
  localparam logic [TB_ADDR_W-1:0] F_COV  = 12'd9;
  localparam logic [TB_ADDR_W-1:0] M_T    = 12'd12;

  // phase boundaries on the shared count
  localparam logic [TB_ADDR_W-1:0] PRD_2_START = 12'd18;
  localparam logic [TB_ADDR_W-1:0] PRD_END     = 12'd35;

  localparam int MAT_N        = 3;
  localparam int NEW_TO_PE_IN = 4;
  localparam int ADDER_TO_NEW = 1;

  function automatic tb_cmd_t tb_rd(input logic [TB_ADDR_W-1:0] addr);
    tb_rd = '{en: 1'b1, we: 1'b0, addr: addr};
  endfunction

  function automatic tb_cmd_t tb_wr(input logic [TB_ADDR_W-1:0] addr);
    tb_wr = '{en: 1'b1, we: 1'b1, addr: addr};
  endfunction

endpackage

// File: rtl/stage_ctrl.sv
`timescale 1ns/1ps

module stage_ctrl
  import pe_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       sys_rst,
  input  stage_e     stage_val,
  input  logic       prd_done,
  output stage_e     stage,
  output logic [2:0] stage_rdy,
  output logic       stage_err
);

  logic [2:0] req;

  // a request only counts while ready is shown
  assign req = stage_val & stage_rdy;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      stage     <= STAGE_IDLE;
      stage_err <= 1'b0;
    end else begin
      case (stage)
        STAGE_IDLE: begin
          case (req)
            3'b000: begin
              stage <= STAGE_IDLE;
            end
            STAGE_PRD, STAGE_NEW, STAGE_UPD: begin
              stage <= stage_e'(req);
            end
            // more than one bit set, stay idle and flag it
            default: begin
              stage_err <= 1'b1;
            end
          endcase
        end
        STAGE_PRD: begin
          if (prd_done) begin
            stage <= STAGE_IDLE;
          end
        end
        // new and update carry no work, back out next cycle
        default: begin
          stage <= STAGE_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      stage_rdy <= RDY_READY;
    end else begin
      stage_rdy <= (stage == STAGE_IDLE) ? RDY_READY : RDY_BUSY;
    end
  end

endmodule

// File: rtl/prd_seq.sv
`timescale 1ns/1ps

module prd_seq
  import pe_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 sys_rst,
  input  stage_e               stage,
  input  logic                 nonlinear_start_val,
  input  logic                 nonlinear_done_rdy,
  output logic                 nonlinear_start_rdy,
  output logic                 nonlinear_done_val,
  output prd_e                 phase,
  output logic [TB_ADDR_W-1:0] count,
  output logic                 prd_done
);

  logic start_xfer;
  logic done_xfer;

  assign start_xfer = nonlinear_start_rdy & nonlinear_start_val;
  assign done_xfer  = nonlinear_done_val & nonlinear_done_rdy;

  // last cycle of PRD_2
  assign prd_done = (phase == PRD_2) && (count == PRD_END);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      phase <= PRD_IDLE;
    end else if (stage != STAGE_PRD) begin
      phase <= PRD_IDLE;
    end else begin
      case (phase)
        PRD_IDLE: begin
          if (start_xfer) begin
            phase <= PRD_NONLINEAR;
          end
        end
        PRD_NONLINEAR: begin
          if (done_xfer) begin
            phase <= PRD_1;
          end
        end
        PRD_1: begin
          if (count == PRD_2_START - 1'b1) begin
            phase <= PRD_2;
          end
        end
        PRD_2: begin
          if (prd_done) begin
            phase <= PRD_IDLE;
          end
        end
        default: begin
          phase <= PRD_IDLE;
        end
      endcase
    end
  end

  // counts only through the two scheduled phases
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      count <= '0;
    end else if ((phase == PRD_1) || ((phase == PRD_2) && !prd_done)) begin
      count <= count + 1'b1;
    end else begin
      count <= '0;
    end
  end

  // levels follow the phase, dropped right after their transfer
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      nonlinear_start_rdy <= 1'b0;
      nonlinear_done_val  <= 1'b0;
    end else begin
      nonlinear_start_rdy <= (stage == STAGE_PRD) && (phase == PRD_IDLE) && !start_xfer;
      nonlinear_done_val  <= (phase == PRD_NONLINEAR) && !done_xfer;
    end
  end

endmodule

// File: rtl/prd_schedule.sv
`timescale 1ns/1ps

module prd_schedule
  import pe_cfg_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  prd_e                 phase,
  input  logic [TB_ADDR_W-1:0] count,
  output logic [LANES-1:0]     a_in_en,
  output logic [LANES-1:0]     b_in_en,
  output logic [LANES-1:0]     m_in_en,
  output logic [LANES-1:0]     c_out_en,
  output m_src_e               m_src,
  output tb_cmd_t              tb_a_cmd,
  output tb_cmd_t              tb_b_cmd,
  output logic                 new_cal_en,
  output logic                 new_cal_done
);

  // only MAT_N lanes hold the 3x3 operands
  localparam logic [LANES-1:0] MAT_LANES = LANES'((1 << MAT_N) - 1);

  // extra accumulate cycles after the last operand enters the PE
  localparam int PE_DRAIN = 2;

  localparam logic [TB_ADDR_W-1:0] RUN_N  = TB_ADDR_W'(MAT_N);
  localparam logic [TB_ADDR_W-1:0] SLOT_N = TB_ADDR_W'(2 * MAT_N);
  localparam logic [TB_ADDR_W-1:0] WB_1   =
    TB_ADDR_W'(NEW_TO_PE_IN + MAT_N + PE_DRAIN + ADDER_TO_NEW);
  localparam logic [TB_ADDR_W-1:0] WB_2   = PRD_2_START + WB_1;
  localparam logic [TB_ADDR_W-1:0] M_RD   = PRD_2_START + TB_ADDR_W'(MAT_N + 1);
  localparam logic [TB_ADDR_W-1:0] CAL_1  = TB_ADDR_W'(NEW_TO_PE_IN);
  localparam logic [TB_ADDR_W-1:0] CAL_2  = PRD_2_START + CAL_1;

  // offsets from each window start, wrap high when before it
  logic [TB_ADDR_W-1:0] rel_rd2;
  logic [TB_ADDR_W-1:0] rel_wb1;
  logic [TB_ADDR_W-1:0] rel_wb2;
  logic [TB_ADDR_W-1:0] rel_m;
  logic [TB_ADDR_W-1:0] rel_cal1;
  logic [TB_ADDR_W-1:0] rel_cal2;

  logic [LANES-1:0] a_en_nxt;
  logic [LANES-1:0] b_en_nxt;
  logic [LANES-1:0] m_en_nxt;
  logic [LANES-1:0] c_en_nxt;
  m_src_e           m_src_nxt;
  tb_cmd_t          a_cmd_nxt;
  tb_cmd_t          b_cmd_nxt;
  logic             cal_en_nxt;
  logic             cal_done_nxt;

  assign rel_rd2  = count - PRD_2_START;
  assign rel_wb1  = count - WB_1;
  assign rel_wb2  = count - WB_2;
  assign rel_m    = count - M_RD;
  assign rel_cal1 = count - CAL_1;
  assign rel_cal2 = count - CAL_2;

  always_comb begin
    a_en_nxt     = '0;
    b_en_nxt     = '0;
    m_en_nxt     = '0;
    c_en_nxt     = '0;
    m_src_nxt    = M_SRC_NONE;
    a_cmd_nxt    = '0;
    b_cmd_nxt    = '0;
    cal_en_nxt   = 1'b0;
    cal_done_nxt = 1'b0;
    case (phase)
      // F_xi * t_cov into F_cov
      PRD_1: begin
        a_en_nxt = MAT_LANES;
        b_en_nxt = MAT_LANES;
        c_en_nxt = MAT_LANES;
        if (count < RUN_N) begin
          a_cmd_nxt = tb_rd(F_XI + count);
          b_cmd_nxt = tb_rd(T_COV + count);
        end else if ((rel_wb1 < SLOT_N) && !rel_wb1[0]) begin
          // one result row every other cycle
          b_cmd_nxt = tb_wr(F_COV + (rel_wb1 >> 1));
        end
        cal_en_nxt   = (rel_cal1 < RUN_N);
        cal_done_nxt = (rel_cal1 == RUN_N);
      end
      // F_cov * F_xi_T plus M into t_cov
      PRD_2: begin
        a_en_nxt  = MAT_LANES;
        b_en_nxt  = MAT_LANES;
        m_en_nxt  = MAT_LANES;
        c_en_nxt  = MAT_LANES;
        m_src_nxt = M_SRC_TB;
        if (rel_rd2 < RUN_N) begin
          a_cmd_nxt = tb_rd(F_COV + rel_rd2);
          b_cmd_nxt = tb_rd(F_XI_T + rel_rd2);
        end else if ((rel_m < SLOT_N) && !rel_m[0]) begin
          // M rows come in on port A
          a_cmd_nxt = tb_rd(M_T + (rel_m >> 1));
        end else if ((rel_wb2 < SLOT_N) && !rel_wb2[0]) begin
          b_cmd_nxt = tb_wr(T_COV + (rel_wb2 >> 1));
        end
        cal_en_nxt   = (rel_cal2 < RUN_N);
        cal_done_nxt = (rel_cal2 == RUN_N);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      a_in_en      <= '0;
      b_in_en      <= '0;
      m_in_en      <= '0;
      c_out_en     <= '0;
      m_src        <= M_SRC_NONE;
      tb_a_cmd     <= '0;
      tb_b_cmd     <= '0;
      new_cal_en   <= 1'b0;
      new_cal_done <= 1'b0;
    end else begin
      a_in_en      <= a_en_nxt;
      b_in_en      <= b_en_nxt;
      m_in_en      <= m_en_nxt;
      c_out_en     <= c_en_nxt;
      m_src        <= m_src_nxt;
      tb_a_cmd     <= a_cmd_nxt;
      tb_b_cmd     <= b_cmd_nxt;
      new_cal_en   <= cal_en_nxt;
      new_cal_done <= cal_done_nxt;
    end
  end

endmodule

// File: rtl/issue_skew.sv
`timescale 1ns/1ps

module issue_skew
  import pe_cfg_pkg::*;
#(
  parameter int LANES      = 4,
  parameter int SKEW_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       sys_rst,
  input  tb_cmd_t                    tb_a_cmd,
  input  tb_cmd_t                    tb_b_cmd,
  input  m_src_e                     m_src,
  output logic [LANES-1:0]           tb_ena,
  output logic [LANES-1:0]           tb_wea,
  output logic [LANES-1:0]           tb_enb,
  output logic [LANES-1:0]           tb_web,
  output logic [LANES*TB_ADDR_W-1:0] tb_addra,
  output logic [LANES*TB_ADDR_W-1:0] tb_addrb,
  output logic [2*LANES-1:0]         m_in_sel
);

  // tap k feeds lane k, one cycle later per lane
  tb_cmd_t a_tap [SKEW_DEPTH];
  tb_cmd_t b_tap [SKEW_DEPTH];
  m_src_e  m_tap [SKEW_DEPTH];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < SKEW_DEPTH; i++) begin
        a_tap[i] <= '0;
        b_tap[i] <= '0;
        m_tap[i] <= M_SRC_NONE;
      end
    end else begin
      a_tap[0] <= tb_a_cmd;
      b_tap[0] <= tb_b_cmd;
      m_tap[0] <= m_src;
      for (int i = 1; i < SKEW_DEPTH; i++) begin
        a_tap[i] <= a_tap[i-1];
        b_tap[i] <= b_tap[i-1];
        m_tap[i] <= m_tap[i-1];
      end
    end
  end

  // flatten taps onto the per-lane bank ports
  for (genvar k = 0; k < LANES; k++) begin : g_lane
    assign tb_ena[k] = a_tap[k].en;
    assign tb_wea[k] = a_tap[k].we;
    assign tb_enb[k] = b_tap[k].en;
    assign tb_web[k] = b_tap[k].we;
    assign tb_addra[k*TB_ADDR_W +: TB_ADDR_W] = a_tap[k].addr;
    assign tb_addrb[k*TB_ADDR_W +: TB_ADDR_W] = b_tap[k].addr;
    assign m_in_sel[k*2 +: 2] = m_tap[k];
  end

endmodule

// File: rtl/pe_config_top.sv
`timescale 1ns/1ps

module pe_config_top
  import pe_cfg_pkg::*;
#(
  parameter int LANES      = 4,
  parameter int SKEW_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       sys_rst,
  // host stage handshake
  input  logic [2:0]                 stage_val,
  output logic [2:0]                 stage_rdy,
  output logic                       stage_err,
  // nonlinear unit
  input  logic                       nonlinear_start_val,
  output logic                       nonlinear_start_rdy,
  output logic                       nonlinear_done_val,
  input  logic                       nonlinear_done_rdy,
  // PE array controls
  output logic [LANES-1:0]           a_in_en,
  output logic [LANES-1:0]           b_in_en,
  output logic [LANES-1:0]           m_in_en,
  output logic [LANES-1:0]           c_out_en,
  output logic [2*LANES-1:0]         m_in_sel,
  // temp bank ports
  output logic [LANES-1:0]           tb_ena,
  output logic [LANES-1:0]           tb_wea,
  output logic [LANES*TB_ADDR_W-1:0] tb_addra,
  output logic [LANES-1:0]           tb_enb,
  output logic [LANES-1:0]           tb_web,
  output logic [LANES*TB_ADDR_W-1:0] tb_addrb,
  output logic                       new_cal_en,
  output logic                       new_cal_done
);

  stage_e               stage;
  logic                 prd_done;
  prd_e                 phase;
  logic [TB_ADDR_W-1:0] count;
  m_src_e               m_src;
  tb_cmd_t              tb_a_cmd;
  tb_cmd_t              tb_b_cmd;

  stage_ctrl u_stage_ctrl (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .stage_val (stage_e'(stage_val)),
    .prd_done  (prd_done),
    .stage     (stage),
    .stage_rdy (stage_rdy),
    .stage_err (stage_err)
  );

  prd_seq u_prd_seq (
    .clk                 (clk),
    .sys_rst             (sys_rst),
    .stage               (stage),
    .nonlinear_start_val (nonlinear_start_val),
    .nonlinear_done_rdy  (nonlinear_done_rdy),
    .nonlinear_start_rdy (nonlinear_start_rdy),
    .nonlinear_done_val  (nonlinear_done_val),
    .phase               (phase),
    .count               (count),
    .prd_done            (prd_done)
  );

  prd_schedule #(
    .LANES (LANES)
  ) u_prd_schedule (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .phase        (phase),
    .count        (count),
    .a_in_en      (a_in_en),
    .b_in_en      (b_in_en),
    .m_in_en      (m_in_en),
    .c_out_en     (c_out_en),
    .m_src        (m_src),
    .tb_a_cmd     (tb_a_cmd),
    .tb_b_cmd     (tb_b_cmd),
    .new_cal_en   (new_cal_en),
    .new_cal_done (new_cal_done)
  );

  issue_skew #(
    .LANES      (LANES),
    .SKEW_DEPTH (SKEW_DEPTH)
  ) u_issue_skew (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .tb_a_cmd (tb_a_cmd),
    .tb_b_cmd (tb_b_cmd),
    .m_src    (m_src),
    .tb_ena   (tb_ena),
    .tb_wea   (tb_wea),
    .tb_enb   (tb_enb),
    .tb_web   (tb_web),
    .tb_addra (tb_addra),
    .tb_addrb (tb_addrb),
    .m_in_sel (m_in_sel)
  );

endmodule

// File: tb/pe_config_ref.svh
`ifndef PE_CONFIG_REF_SVH
`define PE_CONFIG_REF_SVH

// expected lane-0 temp bank traffic for one prediction sequence
// each entry is {write, address}, in issue order
function automatic void build_expected(
  output logic [TB_ADDR_W:0] exp_a [$],
  output logic [TB_ADDR_W:0] exp_b [$],
  output int                 exp_en_cycles,
  output int                 exp_done_pulses,
  output int                 exp_pe_cycles,
  output int                 exp_m_cycles
);
  int f_xi;
  int f_xi_t;
  int t_cov;
  int f_cov;
  int m_t;
  int n;
  int phase_len;
  exp_a     = {};
  exp_b     = {};
  f_xi      = 0;
  f_xi_t    = 3;
  t_cov     = 6;
  f_cov     = 9;
  m_t       = 12;
  n         = 3;
  phase_len = 18;
  // PRD_1 operands, F_xi rows on A and t_cov rows on B
  for (int i = 0; i < n; i++) begin
    exp_a.push_back({1'b0, TB_ADDR_W'(f_xi + i)});
    exp_b.push_back({1'b0, TB_ADDR_W'(t_cov + i)});
  end
  // F_cov result rows
  for (int i = 0; i < n; i++) begin
    exp_b.push_back({1'b1, TB_ADDR_W'(f_cov + i)});
  end
  // PRD_2 operands
  for (int i = 0; i < n; i++) begin
    exp_a.push_back({1'b0, TB_ADDR_W'(f_cov + i)});
    exp_b.push_back({1'b0, TB_ADDR_W'(f_xi_t + i)});
  end
  // M rows come in after the operands
  for (int i = 0; i < n; i++) begin
    exp_a.push_back({1'b0, TB_ADDR_W'(m_t + i)});
  end
  // t_cov written back last
  for (int i = 0; i < n; i++) begin
    exp_b.push_back({1'b1, TB_ADDR_W'(t_cov + i)});
  end
  // one run of n enables and one done per counted phase
  exp_en_cycles   = 2 * n;
  exp_done_pulses = 2;
  // PE enables span both counted phases, M only the second
  exp_pe_cycles = 2 * phase_len;
  exp_m_cycles  = phase_len;
endfunction

`endif

// File: tb/tb_pe_config.sv
`timescale 1ns/1ps

module tb_pe_config
  import pe_cfg_pkg::*;
();

  localparam int LANES        = 4;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_WAIT     = 15;
  localparam int SEQ_CYCLES   = 60;
  localparam int NUM_SEQ      = 3;
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + NUM_SEQ * (SEQ_CYCLES + 2 * MAX_WAIT) + 40;

  // low three lanes carry the 3x3 operands
  localparam logic [LANES-1:0] MAT_EN = 4'b0111;

  logic                       clk;
  logic                       sys_rst;
  logic [2:0]                 stage_val;
  logic [2:0]                 stage_rdy;
  logic                       stage_err;
  logic                       nonlinear_start_val;
  logic                       nonlinear_start_rdy;
  logic                       nonlinear_done_val;
  logic                       nonlinear_done_rdy;
  logic [LANES-1:0]           a_in_en;
  logic [LANES-1:0]           b_in_en;
  logic [LANES-1:0]           m_in_en;
  logic [LANES-1:0]           c_out_en;
  logic [2*LANES-1:0]         m_in_sel;
  logic [LANES-1:0]           tb_ena;
  logic [LANES-1:0]           tb_wea;
  logic [LANES*TB_ADDR_W-1:0] tb_addra;
  logic [LANES-1:0]           tb_enb;
  logic [LANES-1:0]           tb_web;
  logic [LANES*TB_ADDR_W-1:0] tb_addrb;
  logic                       new_cal_en;
  logic                       new_cal_done;

  // lane-0 accesses and strobe totals over the whole run
  logic [TB_ADDR_W:0] got_a [$];
  logic [TB_ADDR_W:0] got_b [$];
  int                 cal_en_total;
  int                 cal_done_total;
  int                 pe_en_total;
  int                 m_en_total;
  int                 m_sel_total;

  int   mon_errs;
  int   cmp_errs;
  int   drv_errs;
  event seq_done;

  `include "pe_config_ref.svh"

  pe_config_top #(
    .LANES      (LANES),
    .SKEW_DEPTH (4)
  ) uut (
    .clk                 (clk),
    .sys_rst             (sys_rst),
    .stage_val           (stage_val),
    .stage_rdy           (stage_rdy),
    .stage_err           (stage_err),
    .nonlinear_start_val (nonlinear_start_val),
    .nonlinear_start_rdy (nonlinear_start_rdy),
    .nonlinear_done_val  (nonlinear_done_val),
    .nonlinear_done_rdy  (nonlinear_done_rdy),
    .a_in_en             (a_in_en),
    .b_in_en             (b_in_en),
    .m_in_en             (m_in_en),
    .c_out_en            (c_out_en),
    .m_in_sel            (m_in_sel),
    .tb_ena              (tb_ena),
    .tb_wea              (tb_wea),
    .tb_addra            (tb_addra),
    .tb_enb              (tb_enb),
    .tb_web              (tb_web),
    .tb_addrb            (tb_addrb),
    .new_cal_en          (new_cal_en),
    .new_cal_done        (new_cal_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // host request, both nonlinear handshakes with random waits, then wait for ready
  task automatic run_prd_sequence();
    int start_wait;
    int done_wait;
    int cycles;
    start_wait = $urandom % (MAX_WAIT + 1);
    done_wait  = $urandom % (MAX_WAIT + 1);
    stage_val = 3'b001;
    @(negedge clk);
    stage_val = 3'b000;
    cycles = 0;
    while (stage_rdy !== 3'b000 && cycles < 4) begin
      @(negedge clk);
      cycles++;
    end
    if (stage_rdy !== 3'b000) begin
      drv_errs++;
      $display("stage_rdy did not drop after a PRD request at %0t", $time);
    end
    repeat (start_wait) @(negedge clk);
    nonlinear_start_val = 1'b1;
    while (!nonlinear_start_rdy) @(negedge clk);
    @(negedge clk);
    nonlinear_start_val = 1'b0;
    while (!nonlinear_done_val) @(negedge clk);
    repeat (done_wait) @(negedge clk);
    nonlinear_done_rdy = 1'b1;
    @(negedge clk);
    nonlinear_done_rdy = 1'b0;
    cycles = 0;
    while (stage_rdy !== RDY_READY && cycles < SEQ_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (stage_rdy !== RDY_READY) begin
      drv_errs++;
      $display("stage_rdy did not return to ready after the sequence at %0t", $time);
    end
    // skewed outputs still trail the schedule by a few cycles
    repeat (4) @(negedge clk);
    -> seq_done;
  endtask

  initial begin : driver
    void'($urandom(67));
    sys_rst             = 1'b1;
    stage_val           = 3'b000;
    nonlinear_start_val = 1'b0;
    nonlinear_done_rdy  = 1'b0;
    mon_errs = 0;
    cmp_errs = 0;
    drv_errs = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    sys_rst = 1'b0;
    @(negedge clk);
    if (stage_rdy !== RDY_READY) begin
      drv_errs++;
      $display("CHECK FAILED stage_rdy: got %h expected %h", stage_rdy, RDY_READY);
    end
    if ({a_in_en, b_in_en, m_in_en, c_out_en} !== '0) begin
      drv_errs++;
      $display("CHECK FAILED {a_in_en,b_in_en,m_in_en,c_out_en}: got %h expected %h",
               {a_in_en, b_in_en, m_in_en, c_out_en}, 16'h0);
    end
    if ({tb_ena, tb_wea, tb_enb, tb_web, tb_addra, tb_addrb} !== '0) begin
      drv_errs++;
      $display("CHECK FAILED {tb_ena,tb_wea,tb_enb,tb_web,tb_addra,tb_addrb}: got %h expected %h",
               {tb_ena, tb_wea, tb_enb, tb_web, tb_addra, tb_addrb}, 112'h0);
    end
    if ({new_cal_en, new_cal_done, nonlinear_start_rdy, nonlinear_done_val, stage_err}
        !== 5'b0) begin
      drv_errs++;
      $display({"CHECK FAILED {new_cal_en,new_cal_done,nonlinear_start_rdy,",
                "nonlinear_done_val,stage_err}: got %h expected %h"},
               {new_cal_en, new_cal_done, nonlinear_start_rdy, nonlinear_done_val,
                stage_err}, 5'h0);
    end
    run_prd_sequence();
    run_prd_sequence();
    if (stage_err !== 1'b0) begin
      drv_errs++;
      $display("CHECK FAILED stage_err: got %h expected %h", stage_err, 1'b0);
    end
    // two bits at once is not a legal stage
    stage_val = 3'b011;
    @(negedge clk);
    stage_val = 3'b000;
    repeat (3) @(negedge clk);
    if (stage_err !== 1'b1) begin
      drv_errs++;
      $display("CHECK FAILED stage_err: got %h expected %h", stage_err, 1'b1);
    end
    if (stage_rdy !== RDY_READY) begin
      drv_errs++;
      $display("CHECK FAILED stage_rdy: got %h expected %h", stage_rdy, RDY_READY);
    end
    run_prd_sequence();
    // let the skewed lanes drain
    repeat (8) @(negedge clk);
    $display("errors: monitor %0d, compare %0d, sequence %0d", mon_errs, cmp_errs, drv_errs);
    if (mon_errs + cmp_errs + drv_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // sampled at the active edge, same values the DUT sees
  initial begin : monitor
    logic [TB_ADDR_W+1:0] hist_a [LANES];
    logic [TB_ADDR_W+1:0] hist_b [LANES];
    logic [1:0]           hist_m [LANES];
    logic [TB_ADDR_W+1:0] lane_a;
    logic [TB_ADDR_W+1:0] lane_b;
    logic                 start_seen;
    logic                 done_seen;
    logic                 prev_cal_en;
    for (int k = 0; k < LANES; k++) begin
      hist_a[k] = '0;
      hist_b[k] = '0;
      hist_m[k] = '0;
    end
    start_seen     = 1'b0;
    done_seen      = 1'b0;
    prev_cal_en    = 1'b0;
    cal_en_total   = 0;
    cal_done_total = 0;
    pe_en_total    = 0;
    m_en_total     = 0;
    m_sel_total    = 0;
    while (sys_rst !== 1'b0) @(posedge clk);
    forever begin
      @(posedge clk);
      // a new host request starts a fresh handshake pair
      if ((stage_rdy == RDY_READY) && (stage_val != 3'b000)) begin
        start_seen = 1'b0;
        done_seen  = 1'b0;
      end
      if (nonlinear_start_rdy && nonlinear_start_val) begin
        start_seen = 1'b1;
        done_seen  = 1'b0;
      end
      if (nonlinear_done_val && nonlinear_done_rdy) begin
        done_seen = start_seen;
      end
      if (((tb_ena | tb_enb) != '0) && !done_seen) begin
        mon_errs++;
        $display("TB port access at %0t before both nonlinear handshakes completed", $time);
      end
      if (tb_ena[0]) begin
        got_a.push_back({tb_wea[0], tb_addra[TB_ADDR_W-1:0]});
      end
      if (tb_enb[0]) begin
        got_b.push_back({tb_web[0], tb_addrb[TB_ADDR_W-1:0]});
      end
      if (new_cal_en) begin
        cal_en_total++;
      end
      if (new_cal_done) begin
        cal_done_total++;
        if (!prev_cal_en) begin
          mon_errs++;
          $display("new_cal_done pulse at %0t does not follow a new_cal_en run", $time);
        end
      end
      prev_cal_en = new_cal_en;
      if ((a_in_en == MAT_EN) && (b_in_en == MAT_EN) && (c_out_en == MAT_EN)) begin
        pe_en_total++;
      end
      if (m_in_en == MAT_EN) begin
        m_en_total++;
      end
      if (m_in_sel[1:0] == M_SRC_TB) begin
        m_sel_total++;
      end
      // lane k should repeat lane 0 from k cycles back
      for (int k = 1; k < LANES; k++) begin
        lane_a = {tb_ena[k], tb_wea[k], tb_addra[k*TB_ADDR_W +: TB_ADDR_W]};
        lane_b = {tb_enb[k], tb_web[k], tb_addrb[k*TB_ADDR_W +: TB_ADDR_W]};
        if (lane_a != hist_a[k]) begin
          mon_errs++;
          $display("CHECK FAILED {tb_ena,tb_wea,tb_addra} lane %0d: got %h expected %h",
                   k, lane_a, hist_a[k]);
        end
        if (lane_b != hist_b[k]) begin
          mon_errs++;
          $display("CHECK FAILED {tb_enb,tb_web,tb_addrb} lane %0d: got %h expected %h",
                   k, lane_b, hist_b[k]);
        end
        if (m_in_sel[k*2 +: 2] != hist_m[k]) begin
          mon_errs++;
          $display("CHECK FAILED m_in_sel lane %0d: got %h expected %h",
                   k, m_in_sel[k*2 +: 2], hist_m[k]);
        end
      end
      for (int d = LANES - 1; d > 1; d--) begin
        hist_a[d] = hist_a[d-1];
        hist_b[d] = hist_b[d-1];
        hist_m[d] = hist_m[d-1];
      end
      hist_a[1] = {tb_ena[0], tb_wea[0], tb_addra[TB_ADDR_W-1:0]};
      hist_b[1] = {tb_enb[0], tb_web[0], tb_addrb[TB_ADDR_W-1:0]};
      hist_m[1] = m_in_sel[1:0];
    end
  end

  // checks the traffic of each finished sequence against the reference
  initial begin : compare
    logic [TB_ADDR_W:0] exp_a [$];
    logic [TB_ADDR_W:0] exp_b [$];
    int exp_en;
    int exp_done;
    int exp_pe;
    int exp_m;
    int a_base;
    int b_base;
    int en_base;
    int done_base;
    int pe_base;
    int m_en_base;
    int m_sel_base;
    int n_a;
    int n_b;
    a_base     = 0;
    b_base     = 0;
    en_base    = 0;
    done_base  = 0;
    pe_base    = 0;
    m_en_base  = 0;
    m_sel_base = 0;
    forever begin
      @(seq_done);
      build_expected(exp_a, exp_b, exp_en, exp_done, exp_pe, exp_m);
      n_a = got_a.size() - a_base;
      n_b = got_b.size() - b_base;
      if (n_a != exp_a.size()) begin
        cmp_errs++;
        $display("CHECK FAILED tb_ena lane 0 accesses: got %h expected %h", n_a, exp_a.size());
      end
      if (n_b != exp_b.size()) begin
        cmp_errs++;
        $display("CHECK FAILED tb_enb lane 0 accesses: got %h expected %h", n_b, exp_b.size());
      end
      for (int i = 0; i < n_a && i < exp_a.size(); i++) begin
        if (got_a[a_base + i] != exp_a[i]) begin
          cmp_errs++;
          $display("CHECK FAILED {tb_wea,tb_addra} access %0d: got %h expected %h",
                   i, got_a[a_base + i], exp_a[i]);
        end
      end
      for (int i = 0; i < n_b && i < exp_b.size(); i++) begin
        if (got_b[b_base + i] != exp_b[i]) begin
          cmp_errs++;
          $display("CHECK FAILED {tb_web,tb_addrb} access %0d: got %h expected %h",
                   i, got_b[b_base + i], exp_b[i]);
        end
      end
      if (cal_en_total - en_base != exp_en) begin
        cmp_errs++;
        $display("CHECK FAILED new_cal_en cycles: got %h expected %h",
                 cal_en_total - en_base, exp_en);
      end
      if (cal_done_total - done_base != exp_done) begin
        cmp_errs++;
        $display("CHECK FAILED new_cal_done pulses: got %h expected %h",
                 cal_done_total - done_base, exp_done);
      end
      if (pe_en_total - pe_base != exp_pe) begin
        cmp_errs++;
        $display("CHECK FAILED {a_in_en,b_in_en,c_out_en} cycles: got %h expected %h",
                 pe_en_total - pe_base, exp_pe);
      end
      if (m_en_total - m_en_base != exp_m) begin
        cmp_errs++;
        $display("CHECK FAILED m_in_en cycles: got %h expected %h",
                 m_en_total - m_en_base, exp_m);
      end
      if (m_sel_total - m_sel_base != exp_m) begin
        cmp_errs++;
        $display("CHECK FAILED m_in_sel lane 0 cycles: got %h expected %h",
                 m_sel_total - m_sel_base, exp_m);
      end
      a_base     = got_a.size();
      b_base     = got_b.size();
      en_base    = cal_en_total;
      done_base  = cal_done_total;
      pe_base    = pe_en_total;
      m_en_base  = m_en_total;
      m_sel_base = m_sel_total;
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("errors: monitor %0d, compare %0d, sequence %0d", mon_errs, cmp_errs, drv_errs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tb
rtl/pe_cfg_pkg.sv
rtl/stage_ctrl.sv
rtl/prd_seq.sv
rtl/prd_schedule.sv
rtl/issue_skew.sv
rtl/pe_config_top.sv
tb/tb_pe_config.sv

// File: Makefile
# Verilator build of the PE configuration controller testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module tb_pe_config -Mdir obj_dir -o sim_pe_config

run: compile
	-./obj_dir/sim_pe_config > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
